//--- common/eth_mac_pkg.sv
// receive MAC types, opcode and state enums, framing, CRC and MAC control constants
`default_nettype none

package eth_mac_pkg;

    // basic field types
    typedef logic [7:0]  byte_t;
    typedef logic [47:0] mac_addr_t;
    typedef logic [15:0] eth_type_t;
    typedef logic [15:0] quanta_t;
    typedef logic [31:0] crc_t;

    // frame byte counter
    localparam int LEN_W = 16;
    typedef logic [LEN_W-1:0] len_t;

    // MAC control opcodes, PFC is only recognised
    typedef enum logic [15:0] {
        MCF_OPCODE_LFC = 16'h0001,
        MCF_OPCODE_PFC = 16'h0101
    } mcf_opcode_t;

    // GMII receive framer states
    typedef enum logic [1:0] {
        RX_IDLE,
        RX_PREAMBLE,
        RX_PAYLOAD,
        RX_DROP
    } rx_state_t;

    // GMII framing
    localparam byte_t PREAMBLE_BYTE = 8'h55;
    localparam byte_t SFD_BYTE = 8'hD5;
    localparam int FCS_LEN = 4;
    localparam len_t MIN_FRAME_LEN = 16'd64;

    // reflected CRC-32, register value left behind by a correct FCS
    localparam crc_t CRC32_POLY = 32'hEDB88320;
    localparam crc_t CRC32_RESIDUE = 32'hDEBB20E3;

    // MAC control frame matching, byte offsets from the first destination byte
    localparam mac_addr_t MCF_ETH_DST = 48'h01_80_C2_00_00_01;
    localparam eth_type_t MCF_ETH_TYPE = 16'h8808;
    localparam len_t MCF_TYPE_OFFSET = 16'd12;
    localparam len_t MCF_OPCODE_OFFSET = 16'd14;
    localparam len_t MCF_QUANTA_OFFSET = 16'd16;

    // one pause quanta is 512 bit times, 64 byte cycles on GMII
    localparam int QUANTA_CYCLES = 64;
    typedef logic [$clog2(QUANTA_CYCLES)-1:0] sub_quanta_t;

endpackage

`default_nettype wire

//--- rx_mac/rx_fcs_crc32.sv
// byte-wide reflected CRC-32 over the received frame with residue check
`default_nettype none

module rx_fcs_crc32 (
    input  wire logic                rx_clk,
    input  wire logic                rx_rst,
    input  wire logic                crc_clear,
    input  wire logic                crc_en,
    input  wire eth_mac_pkg::byte_t  crc_data,
    output logic                     crc_ok
);
    import eth_mac_pkg::*;

    crc_t crc_reg;
    crc_t crc_next;

    // eight LFSR steps, LSB of the byte first
    always_comb begin
        crc_next = crc_reg;
        for (int i = 0; i < 8; i++) begin
            if (crc_next[0] ^ crc_data[i]) begin
                crc_next = (crc_next >> 1) ^ CRC32_POLY;
            end else begin
                crc_next = crc_next >> 1;
            end
        end
    end

    always_ff @(posedge rx_clk or posedge rx_rst) begin
        if (rx_rst) begin
            crc_reg <= '1;
        end else if (crc_clear) begin
            crc_reg <= '1;
        end else if (crc_en) begin
            crc_reg <= crc_next;
        end
    end

    // data plus its own FCS leaves the fixed residue
    assign crc_ok = (crc_reg == CRC32_RESIDUE);

endmodule

`default_nettype wire

//--- rx_mac/gmii_rx_framer.sv
// GMII receive framer with preamble/SFD FSM, FCS hold-back and frame status
`default_nettype none

module gmii_rx_framer (
    input  wire logic                rx_clk,
    input  wire logic                rx_rst,
    input  wire eth_mac_pkg::byte_t  gmii_rxd,
    input  wire logic                gmii_rx_dv,
    input  wire logic                gmii_rx_er,
    input  wire logic                cfg_rx_enable,
    input  wire logic                crc_ok,
    output logic                     crc_clear,
    output logic                     crc_en,
    output eth_mac_pkg::byte_t       crc_data,
    output eth_mac_pkg::byte_t       rx_tdata,
    output logic                     rx_tvalid,
    output logic                     rx_tlast,
    output logic                     rx_tuser,
    output logic                     rx_start_packet,
    output logic                     rx_error_bad_frame,
    output logic                     rx_error_bad_fcs
);
    import eth_mac_pkg::*;

    rx_state_t state;
    byte_t     hold_sr [FCS_LEN+1];
    len_t      frame_len;
    logic      er_seen;
    logic      frame_end;
    logic      frame_bad;

    // SFD restarts the CRC, every frame byte including the FCS is fed
    assign crc_clear = (state == RX_PREAMBLE) && gmii_rx_dv && (gmii_rxd == SFD_BYTE);
    assign crc_en    = (state == RX_PAYLOAD) && gmii_rx_dv;
    assign crc_data  = gmii_rxd;

    // first cycle with dv low closes the frame
    assign frame_end = (state == RX_PAYLOAD) && !gmii_rx_dv;
    assign frame_bad = er_seen || (frame_len < MIN_FRAME_LEN) || !crc_ok;

    always_ff @(posedge rx_clk or posedge rx_rst) begin
        if (rx_rst) begin
            state <= RX_IDLE;
        end else begin
            case (state)
                RX_IDLE: begin
                    if (gmii_rx_dv) begin
                        if (cfg_rx_enable && !gmii_rx_er && gmii_rxd == PREAMBLE_BYTE) begin
                            state <= RX_PREAMBLE;
                        end else begin
                            state <= RX_DROP;
                        end
                    end
                end
                RX_PREAMBLE: begin
                    if (!gmii_rx_dv) begin
                        state <= RX_IDLE;
                    end else if (gmii_rx_er) begin
                        state <= RX_DROP;
                    end else if (gmii_rxd == SFD_BYTE) begin
                        state <= RX_PAYLOAD;
                    end else if (gmii_rxd != PREAMBLE_BYTE) begin
                        state <= RX_DROP;
                    end
                end
                RX_PAYLOAD: begin
                    if (!gmii_rx_dv) begin
                        state <= RX_IDLE;
                    end
                end
                default: begin
                    // wait out the rest of a rejected frame
                    if (!gmii_rx_dv) begin
                        state <= RX_IDLE;
                    end
                end
            endcase
        end
    end

    // length and error tracking for the current frame
    always_ff @(posedge rx_clk or posedge rx_rst) begin
        if (rx_rst) begin
            frame_len <= '0;
            er_seen   <= 1'b0;
        end else if (crc_clear) begin
            frame_len <= '0;
            er_seen   <= 1'b0;
        end else if (crc_en) begin
            if (frame_len != '1) begin
                frame_len <= frame_len + 1'b1;
            end
            er_seen <= er_seen | gmii_rx_er;
        end
    end

    // input register plus FCS hold-back, oldest byte at the top
    always_ff @(posedge rx_clk) begin
        if (crc_en) begin
            hold_sr[0] <= gmii_rxd;
            for (int i = 1; i <= FCS_LEN; i++) begin
                hold_sr[i] <= hold_sr[i-1];
            end
        end
        if (crc_en || frame_end) begin
            rx_tdata <= hold_sr[FCS_LEN];
        end
    end

    always_ff @(posedge rx_clk or posedge rx_rst) begin
        if (rx_rst) begin
            rx_tvalid          <= 1'b0;
            rx_tlast           <= 1'b0;
            rx_tuser           <= 1'b0;
            rx_start_packet    <= 1'b0;
            rx_error_bad_frame <= 1'b0;
            rx_error_bad_fcs   <= 1'b0;
        end else begin
            rx_tvalid          <= 1'b0;
            rx_tlast           <= 1'b0;
            rx_tuser           <= 1'b0;
            rx_start_packet    <= 1'b0;
            rx_error_bad_frame <= 1'b0;
            rx_error_bad_fcs   <= 1'b0;
            if (crc_en && frame_len > len_t'(FCS_LEN)) begin
                // top of the hold-back is payload once FCS_LEN newer bytes arrived
                rx_tvalid       <= 1'b1;
                rx_start_packet <= (frame_len == len_t'(FCS_LEN + 1));
            end else if (frame_end) begin
                rx_tvalid          <= 1'b1;
                rx_tlast           <= 1'b1;
                rx_tuser           <= frame_bad;
                rx_start_packet    <= (frame_len <= len_t'(FCS_LEN + 1));
                rx_error_bad_frame <= frame_bad;
                // GMII error already explains a broken CRC
                rx_error_bad_fcs   <= !crc_ok && !er_seen;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/mac_ctrl_rx.sv
// MAC control frame parser for PAUSE frames with quanta capture
`default_nettype none

module mac_ctrl_rx (
    input  wire logic                rx_clk,
    input  wire logic                rx_rst,
    input  wire eth_mac_pkg::byte_t  rx_tdata,
    input  wire logic                rx_tvalid,
    input  wire logic                rx_tlast,
    input  wire logic                rx_tuser,
    output logic                     mcf_valid,
    output eth_mac_pkg::quanta_t     mcf_quanta,
    output logic                     stat_rx_mcf
);
    import eth_mac_pkg::*;

    len_t        beat_cnt;
    mac_addr_t   dst_reg;
    eth_type_t   type_reg;
    mcf_opcode_t opcode_reg;
    logic        in_dst;
    logic        in_type;
    logic        in_opcode;
    logic        in_quanta;
    logic        hdr_done;
    logic        ctrl_frame;

    // header field windows
    assign in_dst    = beat_cnt < len_t'($bits(mac_addr_t) / 8);
    assign in_type   = (beat_cnt == MCF_TYPE_OFFSET) || (beat_cnt == MCF_TYPE_OFFSET + 1'b1);
    assign in_opcode = (beat_cnt == MCF_OPCODE_OFFSET) ||
                       (beat_cnt == MCF_OPCODE_OFFSET + 1'b1);
    assign in_quanta = (beat_cnt == MCF_QUANTA_OFFSET) ||
                       (beat_cnt == MCF_QUANTA_OFFSET + 1'b1);

    // quanta must be complete before the last beat
    assign hdr_done = beat_cnt > MCF_QUANTA_OFFSET + 1'b1;

    assign ctrl_frame = rx_tvalid && rx_tlast && !rx_tuser && hdr_done &&
                        (type_reg == MCF_ETH_TYPE);

    always_ff @(posedge rx_clk or posedge rx_rst) begin
        if (rx_rst) begin
            beat_cnt <= '0;
        end else if (rx_tvalid) begin
            if (rx_tlast) begin
                beat_cnt <= '0;
            end else if (beat_cnt != '1) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    // fields shift in MSB first, network byte order
    always_ff @(posedge rx_clk) begin
        if (rx_tvalid) begin
            if (in_dst) begin
                dst_reg <= {dst_reg[39:0], rx_tdata};
            end
            if (in_type) begin
                type_reg <= {type_reg[7:0], rx_tdata};
            end
            if (in_opcode) begin
                opcode_reg <= mcf_opcode_t'({opcode_reg[7:0], rx_tdata});
            end
            if (in_quanta) begin
                mcf_quanta <= {mcf_quanta[7:0], rx_tdata};
            end
        end
    end

    always_ff @(posedge rx_clk or posedge rx_rst) begin
        if (rx_rst) begin
            mcf_valid   <= 1'b0;
            stat_rx_mcf <= 1'b0;
        end else begin
            mcf_valid   <= 1'b0;
            stat_rx_mcf <= 1'b0;
            if (ctrl_frame) begin
                stat_rx_mcf <= 1'b1;
                case (opcode_reg)
                    MCF_OPCODE_LFC: mcf_valid <= (dst_reg == MCF_ETH_DST);
                    // priority classes are not handled here
                    MCF_OPCODE_PFC: mcf_valid <= 1'b0;
                    default:        mcf_valid <= 1'b0;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/lfc_pause_rx.sv
// receive pause timer driving rx_lfc_req and the LFC statistics
`default_nettype none

module lfc_pause_rx (
    input  wire logic                  rx_clk,
    input  wire logic                  rx_rst,
    input  wire logic                  mcf_valid,
    input  wire eth_mac_pkg::quanta_t  mcf_quanta,
    input  wire logic                  rx_lfc_en,
    output logic                       rx_lfc_req,
    output logic                       stat_rx_lfc_pkt,
    output logic                       stat_rx_lfc_xon,
    output logic                       stat_rx_lfc_xoff,
    output logic                       stat_rx_lfc_paused
);
    import eth_mac_pkg::*;

    quanta_t     quanta_cnt;
    sub_quanta_t sub_cnt;
    logic        load;
    logic        running;

    // frames are ignored while flow control is off
    assign load    = mcf_valid && rx_lfc_en;
    assign running = (quanta_cnt != '0);

    // quanta countdown, one step per QUANTA_CYCLES byte times
    always_ff @(posedge rx_clk or posedge rx_rst) begin
        if (rx_rst) begin
            quanta_cnt <= '0;
            sub_cnt    <= '0;
        end else if (load) begin
            // new PAUSE restarts the timer, zero quanta is XON
            quanta_cnt <= mcf_quanta;
            sub_cnt    <= '0;
        end else if (running) begin
            if (sub_cnt == sub_quanta_t'(QUANTA_CYCLES - 1)) begin
                sub_cnt    <= '0;
                quanta_cnt <= quanta_cnt - 1'b1;
            end else begin
                sub_cnt <= sub_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge rx_clk or posedge rx_rst) begin
        if (rx_rst) begin
            stat_rx_lfc_pkt  <= 1'b0;
            stat_rx_lfc_xon  <= 1'b0;
            stat_rx_lfc_xoff <= 1'b0;
        end else begin
            stat_rx_lfc_pkt  <= load;
            stat_rx_lfc_xon  <= load && (mcf_quanta == '0);
            stat_rx_lfc_xoff <= load && (mcf_quanta != '0);
        end
    end

    // request follows the timer directly
    assign rx_lfc_req         = running;
    assign stat_rx_lfc_paused = running;

endmodule

`default_nettype wire

//--- logic/eth_mac_1g_rx.sv
// 1G Ethernet MAC receive top level with framer, FCS check, control parser and pause timer
`default_nettype none

module eth_mac_1g_rx (
    input  wire logic                rx_clk,
    input  wire logic                rx_rst,
    input  wire eth_mac_pkg::byte_t  gmii_rxd,
    input  wire logic                gmii_rx_dv,
    input  wire logic                gmii_rx_er,
    input  wire logic                cfg_rx_enable,
    input  wire logic                rx_lfc_en,
    output eth_mac_pkg::byte_t       rx_tdata,
    output logic                     rx_tvalid,
    output logic                     rx_tlast,
    output logic                     rx_tuser,
    output logic                     rx_start_packet,
    output logic                     rx_error_bad_frame,
    output logic                     rx_error_bad_fcs,
    output logic                     stat_rx_mcf,
    output logic                     rx_lfc_req,
    output logic                     stat_rx_lfc_pkt,
    output logic                     stat_rx_lfc_xon,
    output logic                     stat_rx_lfc_xoff,
    output logic                     stat_rx_lfc_paused
);
    import eth_mac_pkg::*;

    // framer to CRC
    logic    crc_clear;
    logic    crc_en;
    byte_t   crc_data;
    logic    crc_ok;

    // parser to pause timer
    logic    mcf_valid;
    quanta_t mcf_quanta;

    gmii_rx_framer i_gmii_rx_framer (
        .rx_clk             (rx_clk),
        .rx_rst             (rx_rst),
        .gmii_rxd           (gmii_rxd),
        .gmii_rx_dv         (gmii_rx_dv),
        .gmii_rx_er         (gmii_rx_er),
        .cfg_rx_enable      (cfg_rx_enable),
        .crc_ok             (crc_ok),
        .crc_clear          (crc_clear),
        .crc_en             (crc_en),
        .crc_data           (crc_data),
        .rx_tdata           (rx_tdata),
        .rx_tvalid          (rx_tvalid),
        .rx_tlast           (rx_tlast),
        .rx_tuser           (rx_tuser),
        .rx_start_packet    (rx_start_packet),
        .rx_error_bad_frame (rx_error_bad_frame),
        .rx_error_bad_fcs   (rx_error_bad_fcs)
    );

    rx_fcs_crc32 i_rx_fcs_crc32 (
        .rx_clk    (rx_clk),
        .rx_rst    (rx_rst),
        .crc_clear (crc_clear),
        .crc_en    (crc_en),
        .crc_data  (crc_data),
        .crc_ok    (crc_ok)
    );

    // taps the output stream, nothing is held back
    mac_ctrl_rx i_mac_ctrl_rx (
        .rx_clk      (rx_clk),
        .rx_rst      (rx_rst),
        .rx_tdata    (rx_tdata),
        .rx_tvalid   (rx_tvalid),
        .rx_tlast    (rx_tlast),
        .rx_tuser    (rx_tuser),
        .mcf_valid   (mcf_valid),
        .mcf_quanta  (mcf_quanta),
        .stat_rx_mcf (stat_rx_mcf)
    );

    lfc_pause_rx i_lfc_pause_rx (
        .rx_clk             (rx_clk),
        .rx_rst             (rx_rst),
        .mcf_valid          (mcf_valid),
        .mcf_quanta         (mcf_quanta),
        .rx_lfc_en          (rx_lfc_en),
        .rx_lfc_req         (rx_lfc_req),
        .stat_rx_lfc_pkt    (stat_rx_lfc_pkt),
        .stat_rx_lfc_xon    (stat_rx_lfc_xon),
        .stat_rx_lfc_xoff   (stat_rx_lfc_xoff),
        .stat_rx_lfc_paused (stat_rx_lfc_paused)
    );

endmodule

`default_nettype wire

//--- test/tb_clk_gen.sv
// testbench clock and reset generator
`default_nettype none

module tb_clk_gen (
    output logic rx_clk,
    output logic rx_rst
);
    localparam int CLK_PERIOD = 40;
    localparam int RST_CYCLES = 8;
    localparam int RELEASE_DELAY = 2;

    initial begin
        rx_clk = 1'b0;
        forever #(CLK_PERIOD / 2) rx_clk = ~rx_clk;
    end

    // reset leaves shortly after an edge, like every other input
    initial begin
        rx_rst = 1'b1;
        repeat (RST_CYCLES) @(posedge rx_clk);
        #RELEASE_DELAY;
        rx_rst = 1'b0;
    end

endmodule

`default_nettype wire

//--- test/tb_eth_mac_1g_rx.sv
// directed receive MAC tests with frame builder, reference CRC, monitor and watchdog
`default_nettype none

module tb_eth_mac_1g_rx;
    import eth_mac_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int DRIVE_DELAY = 2;
    localparam logic [31:0] SEED = 32'h3557f281;
    // ten frames of at most 72 line bytes with settle and gap, then both pauses
    localparam int TEST_CYCLES = 8 + 10 * (72 + 24) + 3 * 64 + 256 * 64;

    logic    rx_clk;
    logic    rx_rst;
    byte_t   gmii_rxd;
    logic    gmii_rx_dv;
    logic    gmii_rx_er;
    logic    cfg_rx_enable;
    logic    rx_lfc_en;
    byte_t   rx_tdata;
    logic    rx_tvalid;
    logic    rx_tlast;
    logic    rx_tuser;
    logic    rx_start_packet;
    logic    rx_error_bad_frame;
    logic    rx_error_bad_fcs;
    logic    stat_rx_mcf;
    logic    rx_lfc_req;
    logic    stat_rx_lfc_pkt;
    logic    stat_rx_lfc_xon;
    logic    stat_rx_lfc_xoff;
    logic    stat_rx_lfc_paused;

    logic [31:0] rng_state;
    byte_t       payload_q[$];
    byte_t       out_q[$];

    // running totals kept by the monitor
    int   cyc = 0;
    int   tlast_cnt = 0;
    int   tlast_cyc = -1;
    int   tlast_beat = 0;
    int   start_cnt = 0;
    int   bad_frame_cnt = 0;
    int   bad_fcs_cnt = 0;
    int   mcf_cnt = 0;
    int   pkt_cnt = 0;
    int   xon_cnt = 0;
    int   xoff_cnt = 0;
    int   high_cnt = 0;
    int   rise_cyc = -1;
    int   fall_cyc = -1;
    logic last_tuser = 1'b0;
    logic lfc_prev = 1'b0;

    // totals at the start of the current test
    int base_beats;
    int base_tlast;
    int base_start;
    int base_bad_frame;
    int base_bad_fcs;
    int base_mcf;
    int base_pkt;
    int base_xon;
    int base_xoff;
    int base_high;

    tb_clk_gen i_tb_clk_gen (
        .rx_clk (rx_clk),
        .rx_rst (rx_rst)
    );

    eth_mac_1g_rx i_eth_mac_1g_rx (
        .rx_clk             (rx_clk),
        .rx_rst             (rx_rst),
        .gmii_rxd           (gmii_rxd),
        .gmii_rx_dv         (gmii_rx_dv),
        .gmii_rx_er         (gmii_rx_er),
        .cfg_rx_enable      (cfg_rx_enable),
        .rx_lfc_en          (rx_lfc_en),
        .rx_tdata           (rx_tdata),
        .rx_tvalid          (rx_tvalid),
        .rx_tlast           (rx_tlast),
        .rx_tuser           (rx_tuser),
        .rx_start_packet    (rx_start_packet),
        .rx_error_bad_frame (rx_error_bad_frame),
        .rx_error_bad_fcs   (rx_error_bad_fcs),
        .stat_rx_mcf        (stat_rx_mcf),
        .rx_lfc_req         (rx_lfc_req),
        .stat_rx_lfc_pkt    (stat_rx_lfc_pkt),
        .stat_rx_lfc_xon    (stat_rx_lfc_xon),
        .stat_rx_lfc_xoff   (stat_rx_lfc_xoff),
        .stat_rx_lfc_paused (stat_rx_lfc_paused)
    );

    task automatic stop_on_failure();
        $display("=== FAIL ===");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_byte(input string test, input int index, input byte_t exp,
                              input byte_t act);
        if (act !== exp) begin
            $display("ERR %s: beat %0d expected %02h actual %02h", test, index, exp, act);
            stop_on_failure();
        end
    endtask

    // status order is tuser, start_packet, bad_frame, bad_fcs
    task automatic check_status(input string test, input logic [3:0] exp,
                                input logic [3:0] act);
        if (act !== exp) begin
            $display("ERR %s: status expected %04b actual %04b", test, exp, act);
            stop_on_failure();
        end
    endtask

    task automatic check_cycles(input string test, input string what, input int exp,
                                input int act);
        if (act != exp) begin
            $display("ERR %s: %s expected %0d cycles actual %0d", test, what, exp, act);
            stop_on_failure();
        end
    endtask

    task automatic check_count(input string test, input string what, input int exp,
                               input int act);
        if (act != exp) begin
            $display("ERR %s: %s expected %0d actual %0d", test, what, exp, act);
            stop_on_failure();
        end
    endtask

    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // IEEE 802.3 FCS, reflected, LSB of each byte first, sent complemented
    function automatic logic [31:0] frame_crc(input byte_t data[$]);
        logic [31:0] c;
        c = 32'hFFFFFFFF;
        foreach (data[i]) begin
            c = c ^ {24'h000000, data[i]};
            for (int b = 0; b < 8; b++) begin
                c = c[0] ? ((c >> 1) ^ 32'hEDB88320) : (c >> 1);
            end
        end
        return ~c;
    endfunction

    // monitor samples at the falling edge, half a cycle away from both drivers
    always @(negedge rx_clk) begin
        if (!rx_rst) begin
            cyc++;
            if (rx_tvalid) begin
                out_q.push_back(rx_tdata);
                if (rx_tlast) begin
                    tlast_cnt++;
                    tlast_cyc = cyc;
                    tlast_beat = out_q.size();
                    last_tuser = rx_tuser;
                end
            end
            start_cnt = start_cnt + int'(rx_start_packet);
            bad_frame_cnt = bad_frame_cnt + int'(rx_error_bad_frame);
            bad_fcs_cnt = bad_fcs_cnt + int'(rx_error_bad_fcs);
            mcf_cnt = mcf_cnt + int'(stat_rx_mcf);
            pkt_cnt = pkt_cnt + int'(stat_rx_lfc_pkt);
            xon_cnt = xon_cnt + int'(stat_rx_lfc_xon);
            xoff_cnt = xoff_cnt + int'(stat_rx_lfc_xoff);
            high_cnt = high_cnt + int'(rx_lfc_req);
            if (rx_lfc_req && !lfc_prev)
                rise_cyc = cyc;
            if (!rx_lfc_req && lfc_prev)
                fall_cyc = cyc;
            lfc_prev = rx_lfc_req;
            if (stat_rx_lfc_paused !== rx_lfc_req) begin
                $display("stat_rx_lfc_paused does not follow rx_lfc_req at cycle %0d", cyc);
                stop_on_failure();
            end
        end
    end

    // interframe gap, then snapshot the totals
    task automatic begin_test();
        repeat (12) @(posedge rx_clk);
        #DRIVE_DELAY;
        base_beats = out_q.size();
        base_tlast = tlast_cnt;
        base_start = start_cnt;
        base_bad_frame = bad_frame_cnt;
        base_bad_fcs = bad_fcs_cnt;
        base_mcf = mcf_cnt;
        base_pkt = pkt_cnt;
        base_xon = xon_cnt;
        base_xoff = xoff_cnt;
        base_high = high_cnt;
    endtask

    task automatic make_random_payload(input int len);
        payload_q.delete();
        for (int i = 0; i < len; i++) begin
            rng_state = next_random(rng_state);
            payload_q.push_back(rng_state[7:0]);
        end
    endtask

    // MAC control frame padded to the 60 byte minimum before FCS
    task automatic make_ctrl_payload(input logic [15:0] opcode, input logic [15:0] quanta);
        byte_t hdr [18];
        hdr = '{8'h01, 8'h80, 8'hC2, 8'h00, 8'h00, 8'h01,
                8'h02, 8'h00, 8'h5E, 8'h10, 8'h20, 8'h30,
                8'h88, 8'h08, opcode[15:8], opcode[7:0], quanta[15:8], quanta[7:0]};
        payload_q.delete();
        foreach (hdr[i])
            payload_q.push_back(hdr[i]);
        while (payload_q.size() < 60)
            payload_q.push_back(8'h00);
    endtask

    // er_index counts from the first byte after the SFD, -1 for none
    task automatic send_frame(input logic corrupt_fcs, input int er_index);
        byte_t       line_q[$];
        logic [31:0] fcs;
        fcs = frame_crc(payload_q);
        if (corrupt_fcs)
            fcs = ~fcs;
        for (int i = 0; i < 7; i++)
            line_q.push_back(8'h55);
        line_q.push_back(8'hD5);
        foreach (payload_q[i])
            line_q.push_back(payload_q[i]);
        for (int i = 0; i < 4; i++)
            line_q.push_back(fcs[8*i +: 8]);
        for (int i = 0; i < line_q.size(); i++) begin
            @(posedge rx_clk);
            #DRIVE_DELAY;
            gmii_rxd   = line_q[i];
            gmii_rx_dv = 1'b1;
            gmii_rx_er = (er_index >= 0) && (i == er_index + 8);
        end
        @(posedge rx_clk);
        #DRIVE_DELAY;
        gmii_rxd   = 8'h00;
        gmii_rx_dv = 1'b0;
        gmii_rx_er = 1'b0;
    endtask

    // lfc stats trail rx_tlast by two cycles
    task automatic wait_frame_end();
        while (tlast_cnt == base_tlast)
            @(posedge rx_clk);
        repeat (3) @(posedge rx_clk);
    endtask

    task automatic check_frame(input string test, input logic [3:0] exp_status);
        logic [3:0] act;
        check_count(test, "output beats", payload_q.size(), out_q.size() - base_beats);
        check_count(test, "frames ended", 1, tlast_cnt - base_tlast);
        check_count(test, "beats up to tlast", payload_q.size(), tlast_beat - base_beats);
        check_count(test, "start pulses", 1, start_cnt - base_start);
        foreach (payload_q[i])
            check_byte(test, i, payload_q[i], out_q[base_beats + i]);
        act = {last_tuser, start_cnt != base_start, bad_frame_cnt != base_bad_frame,
               bad_fcs_cnt != base_bad_fcs};
        check_status(test, exp_status, act);
    endtask

    task automatic check_stats(input string test, input int mcf, input int pkt,
                               input int xon, input int xoff);
        check_count(test, "stat_rx_mcf pulses", mcf, mcf_cnt - base_mcf);
        check_count(test, "stat_rx_lfc_pkt pulses", pkt, pkt_cnt - base_pkt);
        check_count(test, "stat_rx_lfc_xon pulses", xon, xon_cnt - base_xon);
        check_count(test, "stat_rx_lfc_xoff pulses", xoff, xoff_cnt - base_xoff);
    endtask

    task automatic run_good_frame();
        begin_test();
        make_random_payload(60);
        send_frame(1'b0, -1);
        wait_frame_end();
        check_frame("good_frame", 4'b0100);
        check_stats("good_frame", 0, 0, 0, 0);
    endtask

    task automatic run_bad_frames();
        begin_test();
        make_random_payload(60);
        send_frame(1'b1, -1);
        wait_frame_end();
        check_frame("bad_fcs", 4'b1111);
        begin_test();
        make_random_payload(60);
        send_frame(1'b0, 20);
        wait_frame_end();
        check_frame("gmii_error", 4'b1110);
        // 36 bytes plus FCS is a 40 byte runt
        begin_test();
        make_random_payload(36);
        send_frame(1'b0, -1);
        wait_frame_end();
        check_frame("short_frame", 4'b1110);
    endtask

    // one quanta is 512 bit times, 64 byte cycles on GMII
    task automatic run_pause();
        begin_test();
        make_ctrl_payload(16'h0001, 16'h0003);
        send_frame(1'b0, -1);
        wait_frame_end();
        check_frame("pause", 4'b0100);
        check_stats("pause", 1, 1, 0, 1);
        check_cycles("pause", "lfc_req rise after tlast", 2, rise_cyc - tlast_cyc);
        while (fall_cyc <= rise_cyc)
            @(posedge rx_clk);
        check_cycles("pause", "lfc_req high time", 3 * 64, fall_cyc - rise_cyc);
        check_cycles("pause", "lfc_req high samples", 3 * 64, high_cnt - base_high);
    endtask

    task automatic run_pause_xon();
        begin_test();
        make_ctrl_payload(16'h0001, 16'h0100);
        send_frame(1'b0, -1);
        wait_frame_end();
        check_stats("pause_long", 1, 1, 0, 1);
        check_cycles("pause_long", "lfc_req rise after tlast", 2, rise_cyc - tlast_cyc);
        begin_test();
        make_ctrl_payload(16'h0001, 16'h0000);
        send_frame(1'b0, -1);
        wait_frame_end();
        check_stats("xon", 1, 1, 1, 0);
        check_cycles("xon", "lfc_req fall after tlast", 2, fall_cyc - tlast_cyc);
    endtask

    task automatic run_ignored_ctrl();
        begin_test();
        rx_lfc_en = 1'b0;
        make_ctrl_payload(16'h0001, 16'h0003);
        send_frame(1'b0, -1);
        wait_frame_end();
        check_frame("lfc_disabled", 4'b0100);
        check_stats("lfc_disabled", 1, 0, 0, 0);
        check_cycles("lfc_disabled", "lfc_req high samples", 0, high_cnt - base_high);
        begin_test();
        rx_lfc_en = 1'b1;
        make_ctrl_payload(16'h0101, 16'h0003);
        send_frame(1'b0, -1);
        wait_frame_end();
        check_stats("pfc_opcode", 1, 0, 0, 0);
        check_cycles("pfc_opcode", "lfc_req high samples", 0, high_cnt - base_high);
        // a dropped frame gives no end marker, so allow a fixed settle time
        begin_test();
        cfg_rx_enable = 1'b0;
        make_ctrl_payload(16'h0001, 16'h0003);
        send_frame(1'b0, -1);
        repeat (8) @(posedge rx_clk);
        check_count("rx_disabled", "output beats", 0, out_q.size() - base_beats);
        check_count("rx_disabled", "frames ended", 0, tlast_cnt - base_tlast);
        check_stats("rx_disabled", 0, 0, 0, 0);
        #DRIVE_DELAY;
        cfg_rx_enable = 1'b1;
    endtask

    initial begin
        #(2 * TEST_CYCLES * CLK_PERIOD);
        $display("timeout, tests still running after %0d cycles", 2 * TEST_CYCLES);
        stop_on_failure();
    end

    initial begin
        gmii_rxd      = 8'h00;
        gmii_rx_dv    = 1'b0;
        gmii_rx_er    = 1'b0;
        cfg_rx_enable = 1'b1;
        rx_lfc_en     = 1'b1;
        rng_state     = SEED;
        wait (rx_rst == 1'b0);
        run_good_frame();
        run_bad_frames();
        run_pause();
        run_pause_xon();
        run_ignored_ctrl();
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
common/eth_mac_pkg.sv
rx_mac/rx_fcs_crc32.sv
rx_mac/gmii_rx_framer.sv
logic/mac_ctrl_rx.sv
logic/lfc_pause_rx.sv
logic/eth_mac_1g_rx.sv
test/tb_clk_gen.sv
test/tb_eth_mac_1g_rx.sv

//--- run_sim.sh
#!/bin/sh
# build the receive MAC testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_eth_mac_1g_rx -f verilog.f -o sim_eth_mac_1g_rx
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/sim_eth_mac_1g_rx
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed with status $status"
    exit "$status"
fi

exit 0
